// ==== list.f ====
mems_dac_pkg.sv
mems_scan_pkg.sv
mems_rom.sv
mems_control.sv
mems_spi_master.sv
mems_scan_top.sv
tb_mems_scan_top.sv

// ==== mems_control.sv ====
`timescale 1ns/100ps

module mems_control #(
  parameter mems_scan_pkg::scan_code_t UP_LIMIT     = mems_scan_pkg::up_limit_def,
  parameter mems_scan_pkg::scan_code_t DOWN_LIMIT   = mems_scan_pkg::down_limit_def,
  parameter mems_scan_pkg::scan_code_t UP_LIMIT_2   = mems_scan_pkg::up_limit_def,
  parameter mems_scan_pkg::scan_code_t DOWN_LIMIT_2 = mems_scan_pkg::down_limit_def,
  parameter mems_scan_pkg::scan_code_t C_STEP       = mems_scan_pkg::c_step_def
) (
  input  logic                  clk,
  input  logic                  mems_soft_reset,
  input  logic                  pause,
  input  logic                  busy,
  input  logic                  new_line_fifo_done,
  input  logic                  new_frame_fifo_done,
  output logic                  spi_start,
  output mems_dac_pkg::dac_op_t op,
  output logic [7:0]            code_a,
  output logic [7:0]            code_b,
  output logic [7:0]            code_c,
  output logic [7:0]            code_d,
  output logic                  new_line,
  output logic                  new_frame
);
  import mems_dac_pkg::*;
  import mems_scan_pkg::*;

  scan_state_t state;

  logic ready;      // SPI free and no start still in flight
  logic fast_wrap;
  logic slow_wrap;

  // busy needs one cycle to rise after a start
  assign ready     = !busy && !spi_start;
  assign fast_wrap = code_a > UP_LIMIT;
  assign slow_wrap = code_c > UP_LIMIT_2;

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      state     <= st_soft_reset;
      op        <= op_soft_reset;
      spi_start <= 1'b0;
      code_a    <= DOWN_LIMIT;
      code_b    <= UP_LIMIT;
      code_c    <= DOWN_LIMIT_2;
      code_d    <= UP_LIMIT_2;
      new_line  <= 1'b0;
      new_frame <= 1'b0;
    end else begin
      spi_start <= 1'b0;  // single-cycle strobe

      // acks from the FIFO side, a set further down overrides
      if (new_line_fifo_done) begin
        new_line <= 1'b0;
      end
      if (new_frame_fifo_done) begin
        new_frame <= 1'b0;
      end

      case (state)
        st_soft_reset: begin
          if (ready) begin
            op        <= op_soft_reset;
            spi_start <= 1'b1;
            state     <= st_ldac;
          end
        end

        st_ldac: begin
          if (ready) begin
            op        <= op_ldac_setup;
            spi_start <= 1'b1;
            state     <= st_ref;
          end
        end

        st_ref: begin
          if (ready) begin
            op        <= op_ref_enable;
            spi_start <= 1'b1;
            state     <= st_scan;
          end
        end

        st_scan: begin
          // op holds the last word sent and acts as the channel sub-state
          if (ready) begin
            case (op)
              op_write_a: begin
                op        <= op_write_b;
                spi_start <= 1'b1;
              end
              op_write_b: begin
                op        <= op_write_c;
                spi_start <= 1'b1;
              end
              op_write_c: begin
                op        <= op_write_d;
                spi_start <= 1'b1;
              end
              default: begin  // after ref enable or channel D
                if (!pause) begin
                  op        <= op_write_a;
                  spi_start <= 1'b1;
                  if (fast_wrap) begin
                    code_a <= DOWN_LIMIT;
                    code_b <= UP_LIMIT;
                    if (slow_wrap) begin  // end of frame
                      code_c    <= DOWN_LIMIT_2;
                      code_d    <= UP_LIMIT_2;
                      new_frame <= 1'b1;
                    end else begin        // next line
                      code_c   <= code_c + C_STEP;
                      code_d   <= code_d - C_STEP;
                      new_line <= 1'b1;
                    end
                  end else begin
                    code_a <= code_a + 8'd1;  // sawtooth step
                    code_b <= code_b - 8'd1;
                  end
                end
              end
            endcase
          end
        end

        default: state <= st_soft_reset;
      endcase
    end
  end

  // limits that could overflow a slow-axis step
  initial begin
    if (!step_fits(UP_LIMIT_2, C_STEP)) begin
      $error("mems_control: UP_LIMIT_2 + C_STEP exceeds 8 bits");
    end
  end

  a_start_pulse: assert property (
    @(posedge clk) disable iff (mems_soft_reset) spi_start |=> !spi_start
  ) else $error("mems_control: spi_start high two cycles in a row");

  a_start_idle: assert property (
    @(posedge clk) disable iff (mems_soft_reset) !(spi_start && busy)
  ) else $error("mems_control: spi_start while SPI busy");

endmodule

// ==== mems_dac_pkg.sv ====
package mems_dac_pkg;

  localparam int dac_word_w = 24;  // bits per SPI frame

  // sequencer opcodes, one per DAC command word
  typedef enum logic [2:0] {
    op_soft_reset,
    op_ldac_setup,
    op_ref_enable,
    op_write_a,
    op_write_b,
    op_write_c,
    op_write_d
  } dac_op_t;

  // 3-bit DAC command field
  localparam logic [2:0] cmd_write_update = 3'b011;  // write and update channel n
  localparam logic [2:0] cmd_soft_reset   = 3'b101;
  localparam logic [2:0] cmd_ldac_setup   = 3'b110;
  localparam logic [2:0] cmd_ref_setup    = 3'b111;

  // 3-bit channel address field
  localparam logic [2:0] addr_a    = 3'd0;
  localparam logic [2:0] addr_b    = 3'd1;
  localparam logic [2:0] addr_c    = 3'd2;
  localparam logic [2:0] addr_d    = 3'd3;
  localparam logic [2:0] addr_none = 3'd0;  // set-up commands ignore it

  localparam logic [15:0] data_reset  = 16'h0001;
  localparam logic [15:0] data_ldac   = 16'h000F;  // all channels transparent
  localparam logic [15:0] data_ref_on = 16'h0001;

  // two don't care bits, command, address, data
  function automatic logic [dac_word_w-1:0] dac_word(input logic [2:0]  cmd,
                                                     input logic [2:0]  addr,
                                                     input logic [15:0] data);
    return {2'b00, cmd, addr, data};
  endfunction

endpackage

// ==== mems_rom.sv ====
`timescale 1ns/100ps

module mems_rom (
  input  logic                                clk,     // only samples the op check
  input  mems_dac_pkg::dac_op_t               op,
  input  logic [7:0]                          code_a,
  input  logic [7:0]                          code_b,
  input  logic [7:0]                          code_c,
  input  logic [7:0]                          code_d,
  output logic [mems_dac_pkg::dac_word_w-1:0] word
);
  import mems_dac_pkg::*;

  // command table, valid in the same cycle as the start strobe
  always_comb begin
    case (op)
      op_soft_reset: word = dac_word(cmd_soft_reset, addr_none, data_reset);
      op_ldac_setup: word = dac_word(cmd_ldac_setup, addr_none, data_ldac);
      op_ref_enable: word = dac_word(cmd_ref_setup, addr_none, data_ref_on);
      // channel code goes in the upper data byte
      op_write_a:    word = dac_word(cmd_write_update, addr_a, {code_a, 8'h00});
      op_write_b:    word = dac_word(cmd_write_update, addr_b, {code_b, 8'h00});
      op_write_c:    word = dac_word(cmd_write_update, addr_c, {code_c, 8'h00});
      op_write_d:    word = dac_word(cmd_write_update, addr_d, {code_d, 8'h00});
      default:       word = '0;
    endcase
  end

  // sequencer must never hand over the unused 3'd7 code
  a_op_legal: assert property (
    @(posedge clk) !$isunknown(op) |->
      (op inside {op_soft_reset, op_ldac_setup, op_ref_enable,
                  op_write_a, op_write_b, op_write_c, op_write_d})
  ) else $error("mems_rom: illegal opcode %0d", op);

endmodule

// ==== mems_scan_pkg.sv ====
package mems_scan_pkg;

  // 8-bit channel code, upper byte of the DAC data
  typedef logic [7:0] scan_code_t;

  // start-up sequence, then the endless channel loop
  typedef enum logic [1:0] {
    st_soft_reset,
    st_ldac,
    st_ref,
    st_scan
  } scan_state_t;

  // default mirror swing
  localparam scan_code_t up_limit_def   = 8'd154;
  localparam scan_code_t down_limit_def = 8'd34;

  // slow axis advance per line
  localparam scan_code_t c_step_def = 8'd2;

  // keeps the slow axis from running past its range in one step
  function automatic bit step_fits(input scan_code_t up, input scan_code_t step);
    return (int'(up) + int'(step)) < 256;
  endfunction

endpackage

// ==== mems_scan_top.sv ====
`timescale 1ns/100ps

module mems_scan_top #(
  parameter mems_scan_pkg::scan_code_t UP_LIMIT     = mems_scan_pkg::up_limit_def,
  parameter mems_scan_pkg::scan_code_t DOWN_LIMIT   = mems_scan_pkg::down_limit_def,
  parameter mems_scan_pkg::scan_code_t UP_LIMIT_2   = mems_scan_pkg::up_limit_def,
  parameter mems_scan_pkg::scan_code_t DOWN_LIMIT_2 = mems_scan_pkg::down_limit_def,
  parameter mems_scan_pkg::scan_code_t C_STEP       = mems_scan_pkg::c_step_def,
  parameter int                        CLK_DIV      = 4
) (
  input  logic clk,
  input  logic mems_soft_reset,
  input  logic pause,
  input  logic new_line_fifo_done,
  input  logic new_frame_fifo_done,
  output logic sclk,
  output logic mosi,
  output logic sync_n,
  output logic new_line,
  output logic new_frame
);
  import mems_dac_pkg::*;

  logic                  spi_start;
  logic                  busy;
  dac_op_t               op;
  logic [7:0]            code_a;
  logic [7:0]            code_b;
  logic [7:0]            code_c;
  logic [7:0]            code_d;
  logic [dac_word_w-1:0] word;

  mems_control #(
    .UP_LIMIT     (UP_LIMIT),
    .DOWN_LIMIT   (DOWN_LIMIT),
    .UP_LIMIT_2   (UP_LIMIT_2),
    .DOWN_LIMIT_2 (DOWN_LIMIT_2),
    .C_STEP       (C_STEP)
  ) i_mems_control (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .pause               (pause),
    .busy                (busy),
    .new_line_fifo_done  (new_line_fifo_done),
    .new_frame_fifo_done (new_frame_fifo_done),
    .spi_start           (spi_start),
    .op                  (op),
    .code_a              (code_a),
    .code_b              (code_b),
    .code_c              (code_c),
    .code_d              (code_d),
    .new_line            (new_line),
    .new_frame           (new_frame)
  );

  mems_rom i_mems_rom (
    .clk    (clk),
    .op     (op),
    .code_a (code_a),
    .code_b (code_b),
    .code_c (code_c),
    .code_d (code_d),
    .word   (word)
  );

  mems_spi_master #(
    .CLK_DIV (CLK_DIV)
  ) i_mems_spi_master (
    .clk             (clk),
    .mems_soft_reset (mems_soft_reset),
    .start           (spi_start),
    .word            (word),
    .busy            (busy),
    .sclk            (sclk),
    .mosi            (mosi),
    .sync_n          (sync_n)
  );

endmodule

// ==== mems_spi_master.sv ====
`timescale 1ns/100ps

module mems_spi_master #(
  parameter int CLK_DIV = 4  // clk cycles per sclk half period
) (
  input  logic                                clk,
  input  logic                                mems_soft_reset,
  input  logic                                start,
  input  logic [mems_dac_pkg::dac_word_w-1:0] word,
  output logic                                busy,
  output logic                                sclk,
  output logic                                mosi,
  output logic                                sync_n
);
  import mems_dac_pkg::*;

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

  logic [DIV_W-1:0]      div_cnt;
  logic [4:0]            bit_cnt;
  logic [dac_word_w-1:0] shreg;
  logic                  tick;      // end of a half period
  logic                  fall_edge;
  logic                  last_bit;

  assign tick      = (div_cnt == DIV_W'(CLK_DIV - 1));
  assign fall_edge = busy && tick && sclk;
  assign last_bit  = (bit_cnt == 5'(dac_word_w - 1));
  assign mosi      = shreg[dac_word_w-1];  // MSB first

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      shreg <= word;
    end else if (fall_edge && !last_bit) begin
      shreg <= shreg << 1;  // next bit on the falling edge
    end
  end

  always_ff @(posedge clk) begin
    if (mems_soft_reset) begin
      busy    <= 1'b0;
      sclk    <= 1'b0;
      sync_n  <= 1'b1;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        sync_n  <= 1'b0;
        div_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (tick) begin
      div_cnt <= '0;
      sclk    <= !sclk;
      if (sclk) begin
        if (last_bit) begin  // 24th falling edge closes the frame
          busy   <= 1'b0;
          sync_n <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 5'd1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  a_sync_busy: assert property (
    @(posedge clk) disable iff (mems_soft_reset) sync_n == !busy
  ) else $error("mems_spi_master: sync_n and busy out of step");

endmodule

// ==== tb_mems_scan_top.sv ====
`timescale 1ns/100ps

module tb_mems_scan_top;
  import mems_dac_pkg::*;
  import mems_scan_pkg::*;

  localparam scan_code_t up_limit     = 8'd38;
  localparam scan_code_t down_limit   = 8'd34;
  localparam scan_code_t up_limit_2   = 8'd40;
  localparam scan_code_t down_limit_2 = 8'd34;
  localparam scan_code_t c_step       = 8'd2;
  localparam int         clk_div      = 1;

  // run length, in A/B/C/D loops
  localparam int frames_to_run   = 3;
  localparam int loops_per_line  = up_limit - down_limit + 2;
  localparam int lines_per_frame = (up_limit_2 - down_limit_2) / c_step + 2;
  localparam int words_expected  = 3 + 4 * loops_per_line * lines_per_frame * frames_to_run;
  localparam int timeout_cycles  = words_expected * (48 * clk_div + 8) * 4;

  logic clk = 1'b0;
  logic mems_soft_reset;
  logic pause;
  logic new_line_fifo_done;
  logic new_frame_fifo_done;
  logic sclk;
  logic mosi;
  logic sync_n;
  logic new_line;
  logic new_frame;

  // reference model
  scan_state_t           m_state;
  dac_op_t               m_op;     // next channel write
  scan_code_t            m_a;
  scan_code_t            m_b;
  scan_code_t            m_c;
  scan_code_t            m_d;
  logic                  exp_line;
  logic                  exp_frame;
  int                    last_line_clear;   // edge where the last ack took effect
  int                    last_frame_clear;
  logic                  check_line_due;
  logic                  check_frame_due;

  // SPI monitor
  int                    cyc;
  int                    start_edge;
  int                    last_end;
  int                    pause_start;
  int                    nbits;
  int                    frames_seen;
  int                    pause_left;
  logic                  prev_sclk;
  logic                  prev_sync_n;
  logic                  prev_pause;
  logic                  paused_at_start;
  logic                  run_done;
  logic [dac_word_w-1:0] cap;

  always #50 clk = ~clk;

  mems_scan_top #(
    .UP_LIMIT     (up_limit),
    .DOWN_LIMIT   (down_limit),
    .UP_LIMIT_2   (up_limit_2),
    .DOWN_LIMIT_2 (down_limit_2),
    .C_STEP       (c_step),
    .CLK_DIV      (clk_div)
  ) i_mems_scan_top (
    .clk                 (clk),
    .mems_soft_reset     (mems_soft_reset),
    .pause               (pause),
    .new_line_fifo_done  (new_line_fifo_done),
    .new_frame_fifo_done (new_frame_fifo_done),
    .sclk                (sclk),
    .mosi                (mosi),
    .sync_n              (sync_n),
    .new_line            (new_line),
    .new_frame           (new_frame)
  );

  task automatic report_failure(input string msg);
    $display("%0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input logic [dac_word_w-1:0] exp,
                            input logic [dac_word_w-1:0] act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %06h, got %06h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "flag mismatch");
    end
  endtask

  // don't care bits, command, address, data
  function automatic logic [dac_word_w-1:0] cmd_word(input logic [2:0] cmd,
                                                     input logic [2:0] addr,
                                                     input logic [15:0] data);
    return {2'b00, cmd, addr, data};
  endfunction

  task automatic process_word(input logic [dac_word_w-1:0] act);
    logic [dac_word_w-1:0] exp;
    logic is_a;
    logic line_set;
    logic frame_set;
    is_a      = 1'b0;
    line_set  = 1'b0;
    frame_set = 1'b0;
    case (m_state)
      st_soft_reset: begin
        exp     = cmd_word(cmd_soft_reset, 3'd0, 16'h0001);
        m_state = st_ldac;
      end
      st_ldac: begin
        exp     = cmd_word(cmd_ldac_setup, 3'd0, 16'h000F);
        m_state = st_ref;
      end
      st_ref: begin
        exp     = cmd_word(cmd_ref_setup, 3'd0, 16'h0001);
        m_state = st_scan;
      end
      default: begin
        case (m_op)
          op_write_a: begin
            is_a = 1'b1;
            if (m_a > up_limit) begin  // fast axis wrap
              m_a = down_limit;
              m_b = up_limit;
              if (m_c > up_limit_2) begin
                m_c       = down_limit_2;
                m_d       = up_limit_2;
                frame_set = 1'b1;
              end else begin
                m_c      = m_c + c_step;
                m_d      = m_d - c_step;
                line_set = 1'b1;
              end
            end else begin
              m_a = m_a + 8'd1;
              m_b = m_b - 8'd1;
            end
            exp  = cmd_word(cmd_write_update, 3'd0, {m_a, 8'h00});
            m_op = op_write_b;
          end
          op_write_b: begin
            exp  = cmd_word(cmd_write_update, 3'd1, {m_b, 8'h00});
            m_op = op_write_c;
          end
          op_write_c: begin
            exp  = cmd_word(cmd_write_update, 3'd2, {m_c, 8'h00});
            m_op = op_write_d;
          end
          default: begin
            exp  = cmd_word(cmd_write_update, 3'd3, {m_d, 8'h00});
            m_op = op_write_a;
          end
        endcase
      end
    endcase
    check_word("spi word", exp, act);
    if (is_a) begin
      if (paused_at_start) begin
        report_failure("channel A word started while pause was held");
      end
      // set happened at the start edge, unless an ack came later
      if (line_set && last_line_clear <= start_edge) exp_line = 1'b1;
      if (frame_set && last_frame_clear <= start_edge) exp_frame = 1'b1;
      check_flag("new_line", exp_line, new_line);
      check_flag("new_frame", exp_frame, new_frame);
      if (frame_set) begin
        frames_seen = frames_seen + 1;
        if (frames_seen == frames_to_run) run_done = 1'b1;
      end
    end
  endtask

  // everything sampled on clk, values from the previous edge
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > timeout_cycles) begin
      report_failure($sformatf("timeout after %0d cycles, model still in %s",
                               cyc, m_state.name()));
    end
    if (mems_soft_reset) begin
      prev_sclk   = 1'b0;
      prev_sync_n = 1'b1;
      prev_pause  = 1'b0;
    end else begin
      if (check_line_due) check_flag("new_line", exp_line, new_line);
      if (check_frame_due) check_flag("new_frame", exp_frame, new_frame);
      check_line_due  = 1'b0;
      check_frame_due = 1'b0;
      if (pause && !prev_pause) pause_start = cyc;
      if (prev_sync_n && !sync_n) begin
        start_edge      = cyc - 2;  // start strobe one edge before sync_n fell
        paused_at_start = pause && (pause_start < last_end);
        nbits           = 0;
      end
      if (!prev_sclk && sclk) begin
        if (sync_n) report_failure("sclk rose while sync_n was high");
        cap   = {cap[dac_word_w-2:0], mosi};
        nbits = nbits + 1;
      end
      if (!prev_sync_n && sync_n) begin
        last_end = cyc - 1;
        if (nbits != dac_word_w) begin
          report_failure($sformatf("word had %0d sclk edges instead of %0d",
                                   nbits, dac_word_w));
        end
        process_word(cap);
      end
      if (new_line_fifo_done) begin  // clears on this edge
        exp_line        = 1'b0;
        last_line_clear = cyc;
        check_line_due  = 1'b1;
      end
      if (new_frame_fifo_done) begin
        exp_frame        = 1'b0;
        last_frame_clear = cyc;
        check_frame_due  = 1'b1;
      end
      prev_sclk   = sclk;
      prev_sync_n = sync_n;
      prev_pause  = pause;
    end
  end

  initial begin
    void'($urandom(32'h86924847));
    mems_soft_reset     = 1'b1;
    pause               = 1'b0;
    new_line_fifo_done  = 1'b0;
    new_frame_fifo_done = 1'b0;
    m_state          = st_soft_reset;
    m_op             = op_write_a;
    m_a              = down_limit;
    m_b              = up_limit;
    m_c              = down_limit_2;
    m_d              = up_limit_2;
    exp_line         = 1'b0;
    exp_frame        = 1'b0;
    last_line_clear  = 0;
    last_frame_clear = 0;
    check_line_due   = 1'b0;
    check_frame_due  = 1'b0;
    cyc              = 0;
    start_edge       = 0;
    last_end         = 0;
    pause_start      = 0;
    nbits            = 0;
    frames_seen      = 0;
    pause_left       = 0;
    paused_at_start  = 1'b0;
    run_done         = 1'b0;
    cap              = '0;
    repeat (3) @(posedge clk);
    #10 mems_soft_reset = 1'b0;
    forever begin
      @(posedge clk);
      #10;
      new_line_fifo_done  = 1'b0;
      new_frame_fifo_done = 1'b0;
      if (pause_left > 0) begin
        pause_left = pause_left - 1;
        if (pause_left == 0) pause = 1'b0;
      end else if ($urandom % 512 == 0) begin  // long runs, high about 1 in 8
        pause      = 1'b1;
        pause_left = 32 + $urandom % 96;
      end
      // acks only mid-word, so no start lands on the same edge
      if (new_line && !sync_n && $urandom % 32 == 0) new_line_fifo_done = 1'b1;
      if (new_frame && !sync_n && $urandom % 32 == 0) new_frame_fifo_done = 1'b1;
    end
  end

  initial begin
    wait (run_done === 1'b1);
    $display("NO ERRORS");
    $finish;
  end

endmodule
